/* project.f */
hw/periphPkg.sv
hw/byteFifo.sv
hw/uartTx.sv
hw/uartRx.sv
hw/usecTimer.sv
hw/periphRegs.sv
hw/periphTop.sv
testbench/periphTopTb.sv

/* Bender.yml */
package:
  name: periphTop

sources:
  - hw/periphPkg.sv
  - hw/byteFifo.sv
  - hw/uartTx.sv
  - hw/uartRx.sv
  - hw/usecTimer.sv
  - hw/periphRegs.sv
  - hw/periphTop.sv
  - target: simulation
    files:
      - testbench/periphTopTb.sv

/* testbench/periphTopTb.sv */
// testbench for the peripheral block top level
// drives AXI4-Lite accesses and the UART line, checks against reference models
`timescale 1ns/100ps
`default_nettype none

module periphTopTb;

	// several times the summed length of the tests
	localparam int cycleLimit = 40000;
	localparam int timerWait = 2000;

	logic        clock;
	logic        rst;
	logic        awvalid;
	logic        awready;
	logic [11:0] awaddr;
	logic        wvalid;
	logic        wready;
	logic [31:0] wdata;
	logic        bvalid;
	logic        bready;
	logic [1:0]  bresp;
	logic        arvalid;
	logic        arready;
	logic [11:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        txd;
	logic        rxd;
	logic [31:0] gpioIn;
	logic [31:0] gpioOut;
	logic [31:0] gpioDir;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int txDecoded = 0;
	int lastArCycle = 0;
	string testName = "setup";
	logic [31:0] rngState = 32'h6afcb071;
	logic [7:0] expectedTx [$];
	logic [31:0] pinsOut;
	logic [31:0] pinsDir;
	logic [31:0] gpioOutModel = '0;
	logic [31:0] gpioDirModel = '0;

	periphTop dut
	(
		.clock(clock), .rst(rst),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.txd(txd), .rxd(rxd),
		.gpioIn(gpioIn), .gpioOut(gpioOut), .gpioDir(gpioDir)
	);

	always #4 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] gpioModel(input logic [31:0] current,
		input logic [11:0] addr, input logic [31:0] data);
		case (addr)
			periphPkg::gpioOut: return data;
			periphPkg::gpioSet: return current | data;
			periphPkg::gpioClr: return current & ~data;
			default:            return current;
		endcase
	endfunction

	// bits 3..0 are txFull, txEmpty, rxFull, rxReady
	function automatic logic [31:0] statusModel(input int txCount, input int rxCount);
		logic [31:0] status;
		status = '0;
		status[3] = txCount == periphPkg::fifoDepth;
		status[2] = txCount == 0;
		status[1] = rxCount == periphPkg::fifoDepth;
		status[0] = rxCount != 0;
		return status;
	endfunction

	// ticks in a window of cycles, one carry per 65536 / tickStep clocks
	function automatic longint unsigned timerLow(input longint unsigned cycles);
		return (cycles * periphPkg::tickStep) / 65536;
	endfunction

	function automatic longint unsigned timerHigh(input longint unsigned cycles);
		return (cycles * periphPkg::tickStep + 65535) / 65536 + 1;
	endfunction

	task automatic checkWord(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED %s: %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic checkResp(input string what, input periphPkg::axiResp expected,
		input periphPkg::axiResp actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED %s: %s expected %0d actual %0d", testName, what, expected, actual);
		end
	endtask

	task automatic checkByte(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("CHECK FAILED %s: %s expected %h actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("%s: %s", testName, what);
	endtask

	// starts and ends 1 ns after a rising edge
	task automatic axiWrite(input logic [11:0] addr, input logic [31:0] data,
		input int stall, output periphPkg::axiResp resp);
		int waited;
		waited = 0;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = stall == 0;
		@(negedge clock);
		while (!(awready && wready) && waited < 20)
		begin
			@(negedge clock);
			waited++;
		end
		if (!(awready && wready))
			reportFailure("write address and data never accepted together");
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clock);
		pinsOut = gpioOut;
		pinsDir = gpioDir;
		resp = periphPkg::axiResp'(bresp);
		if (!bvalid)
			reportFailure("no write response one cycle after the handshake");
		repeat (stall)
		begin
			@(negedge clock);
			if (!bvalid)
				reportFailure("write response dropped while bready was low");
			checkResp("bresp during stall", resp, periphPkg::axiResp'(bresp));
		end
		if (stall > 0)
		begin
			@(posedge clock);
			#1;
			bready = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic axiRead(input logic [11:0] addr, input int stall,
		output logic [31:0] data, output periphPkg::axiResp resp);
		int waited;
		waited = 0;
		araddr = addr;
		arvalid = 1'b1;
		rready = stall == 0;
		@(negedge clock);
		while (!arready && waited < 20)
		begin
			@(negedge clock);
			waited++;
		end
		if (!arready)
			reportFailure("read address never accepted");
		@(posedge clock);
		#1;
		lastArCycle = cycleCount;
		arvalid = 1'b0;
		@(negedge clock);
		data = rdata;
		resp = periphPkg::axiResp'(rresp);
		if (!rvalid)
			reportFailure("no read response one cycle after the handshake");
		repeat (stall)
		begin
			@(negedge clock);
			if (!rvalid)
				reportFailure("read response dropped while rready was low");
			checkWord("rdata during stall", data, rdata);
			checkResp("rresp during stall", resp, periphPkg::axiResp'(rresp));
		end
		if (stall > 0)
		begin
			@(posedge clock);
			#1;
			rready = 1'b1;
		end
		@(posedge clock);
		#1;
	endtask

	task automatic gpioWriteCheck(input logic [11:0] addr, input logic [31:0] data,
		input int stall);
		periphPkg::axiResp resp;
		axiWrite(addr, data, stall, resp);
		checkResp("gpio write response", periphPkg::okay, resp);
		if (addr == periphPkg::gpioDir)
			gpioDirModel = data;
		else
			gpioOutModel = gpioModel(gpioOutModel, addr, data);
		checkWord("gpioOut pins after write", gpioOutModel, pinsOut);
		checkWord("gpioDir pins after write", gpioDirModel, pinsDir);
	endtask

	task automatic gpioReadCheck(input logic [11:0] addr, input int stall);
		periphPkg::axiResp resp;
		logic [31:0] data;
		axiRead(addr, stall, data, resp);
		checkResp("gpio read response", periphPkg::okay, resp);
		checkWord("gpio readback", (addr == periphPkg::gpioDir) ? gpioDirModel : gpioOutModel,
			data);
	endtask

	// one 8N1 frame on rxd
	task automatic sendRxByte(input logic [7:0] value);
		rxd = 1'b0;
		repeat (periphPkg::bitClocks) @(posedge clock);
		#1;
		for (int i = 0; i < 8; i++)
		begin
			rxd = value[i];
			repeat (periphPkg::bitClocks) @(posedge clock);
			#1;
		end
		rxd = 1'b1;
		repeat (periphPkg::bitClocks) @(posedge clock);
		#1;
	endtask

	// txd monitor, samples near each bit center
	initial
	begin
		logic [7:0] got;
		logic frameOk;
		wait (rst === 1'b0);
		forever
		begin
			@(negedge clock);
			if (txd === 1'b0)
			begin
				frameOk = 1'b1;
				repeat (periphPkg::bitClocks / 2 - 1) @(negedge clock);
				if (txd !== 1'b0)
					frameOk = 1'b0;
				for (int i = 0; i < 8; i++)
				begin
					repeat (periphPkg::bitClocks) @(negedge clock);
					got[i] = txd;
				end
				repeat (periphPkg::bitClocks) @(negedge clock);
				if (txd !== 1'b1)
					frameOk = 1'b0;
				if (!frameOk)
					reportFailure("bad start or stop bit on txd");
				if (expectedTx.size() == 0)
					reportFailure("frame on txd with no byte queued");
				else
					checkByte("txd byte", expectedTx.pop_front(), got);
				txDecoded++;
			end
		end
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount == cycleLimit)
		begin
			$display("timeout: run stopped after %0d cycles", cycleCount);
			$display("checks %0d errors %0d", checkCount, errorCount + 1);
			$display("test failed");
			$finish;
		end
	end

	initial
	begin
		periphPkg::axiResp resp;
		logic [31:0] data;
		logic [7:0] rxBytes [9];
		logic [63:0] t0;
		logic [63:0] t1;
		longint unsigned elapsed;
		longint unsigned delta;
		int startCycle;
		clock = 1'b0;
		rst = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		rxd = 1'b1;
		gpioIn = '0;
		repeat (2) @(posedge clock);
		#1;
		rst = 1'b0;

		testName = "reset and gpio";
		@(negedge clock);
		checkWord("gpioOut after reset", '0, gpioOut);
		checkWord("gpioDir after reset", '0, gpioDir);
		checkWord("ready and valid after reset", '0, {awready, wready, bvalid, arready, rvalid});
		checkWord("txd after reset", 32'd1, {31'b0, txd});
		@(posedge clock);
		#1;
		for (int n = 0; n < 4; n++)
		begin
			rngState = xorshift(rngState);
			gpioWriteCheck(periphPkg::gpioOut, rngState, 0);
			rngState = xorshift(rngState);
			gpioWriteCheck(periphPkg::gpioDir, rngState, 0);
			rngState = xorshift(rngState);
			gpioWriteCheck(periphPkg::gpioSet, rngState, 0);
			rngState = xorshift(rngState);
			gpioWriteCheck(periphPkg::gpioClr, rngState, 0);
			gpioReadCheck(periphPkg::gpioOut, 0);
			gpioReadCheck(periphPkg::gpioDir, 0);
		end
		rngState = xorshift(rngState);
		gpioIn = rngState;
		axiRead(periphPkg::gpioIn, 0, data, resp);
		checkWord("gpioIn readback", gpioIn, data);
		axiRead(periphPkg::gpioSet, 0, data, resp);
		checkWord("gpioSet reads zero", '0, data);

		// the first byte leaves the FIFO at once, eight more fill it
		testName = "uart transmit";
		for (int n = 0; n < 9; n++)
		begin
			rngState = xorshift(rngState);
			expectedTx.push_back(rngState[7:0]);
			axiWrite(periphPkg::uartTxData, {24'b0, rngState[7:0]}, 0, resp);
			checkResp("tx data write", periphPkg::okay, resp);
		end
		axiRead(periphPkg::uartStatus, 0, data, resp);
		checkWord("status with tx FIFO full", statusModel(periphPkg::fifoDepth, 0), data);
		while (txDecoded < 9)
			@(posedge clock);
		#1;
		axiRead(periphPkg::uartStatus, 0, data, resp);
		checkWord("status after transmit", statusModel(0, 0), data);

		testName = "uart receive";
		for (int n = 0; n < 9; n++)
		begin
			rngState = xorshift(rngState);
			rxBytes[n] = rngState[7:0];
			sendRxByte(rxBytes[n]);
		end
		repeat (periphPkg::bitClocks) @(posedge clock);
		#1;
		axiRead(periphPkg::uartStatus, 0, data, resp);
		checkWord("status with rx FIFO full", statusModel(0, periphPkg::fifoDepth), data);
		for (int n = 0; n < periphPkg::fifoDepth; n++)
		begin
			axiRead(periphPkg::uartRxData, 0, data, resp);
			checkResp("rx data read", periphPkg::okay, resp);
			checkByte("rx byte", rxBytes[n], data[7:0]);
		end
		axiRead(periphPkg::uartRxData, 0, data, resp);
		checkWord("read of empty rx FIFO", '0, data);

		testName = "timer";
		axiRead(periphPkg::timerLo, 0, data, resp);
		t0[31:0] = data;
		startCycle = lastArCycle;
		axiRead(periphPkg::timerHi, 0, data, resp);
		t0[63:32] = data;
		// count starts at zero, so its upper word is bounded by the run length
		checkWord("timerHi latch", 32'(timerHigh(longint'(lastArCycle)) >> 32), data);
		repeat (timerWait) @(posedge clock);
		#1;
		axiRead(periphPkg::timerLo, 0, data, resp);
		t1[31:0] = data;
		elapsed = longint'(lastArCycle - startCycle);
		axiRead(periphPkg::timerHi, 0, data, resp);
		t1[63:32] = data;
		checkWord("timerHi latch", 32'(timerHigh(longint'(lastArCycle)) >> 32), data);
		delta = t1 - t0;
		checkCount++;
		if (delta < timerLow(elapsed) || delta > timerHigh(elapsed))
		begin
			errorCount++;
			$display("CHECK FAILED %s: delta over %0d cycles expected %0d..%0d actual %0d",
				testName, elapsed, timerLow(elapsed), timerHigh(elapsed), delta);
		end

		testName = "bus rules";
		axiWrite(12'h040, 32'hffff_ffff, 0, resp);
		checkResp("unmapped write", periphPkg::slvErr, resp);
		axiRead(12'h040, 0, data, resp);
		checkResp("unmapped read", periphPkg::slvErr, resp);
		checkWord("unmapped read data", '0, data);
		axiRead(12'hffc, 0, data, resp);
		checkResp("unmapped read", periphPkg::slvErr, resp);
		for (int n = 0; n < 12; n++)
		begin
			rngState = xorshift(rngState);
			case (rngState[1:0])
				2'd0: gpioWriteCheck(periphPkg::gpioOut, xorshift(rngState), rngState[9:8]);
				2'd1: gpioWriteCheck(periphPkg::gpioSet, xorshift(rngState), rngState[9:8]);
				2'd2: gpioWriteCheck(periphPkg::gpioClr, xorshift(rngState), rngState[9:8]);
				default: gpioWriteCheck(periphPkg::gpioDir, xorshift(rngState), rngState[9:8]);
			endcase
			gpioReadCheck(periphPkg::gpioOut, rngState[11:10]);
			gpioReadCheck(periphPkg::gpioDir, rngState[13:12]);
		end

		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/periphTop.sv */
// peripheral block top level for the soft CPU bus
// AXI4-Lite slave with timer, UART and GPIO behind it
`timescale 1ns/100ps
`default_nettype none

module periphTop
(
	input  logic        clock,
	input  logic        rst,

	input  logic        awvalid,
	output logic        awready,
	input  logic [11:0] awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [11:0] araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,

	output logic        txd,
	input  logic        rxd,

	input  logic [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir
);

	logic txPush;
	logic [7:0] txByte;
	logic txFull;
	logic txEmpty;
	logic txPop;
	logic [7:0] txHead;
	logic rxPush;
	logic [7:0] rxByte;
	logic rxPop;
	logic [7:0] rxHead;
	logic rxFull;
	logic rxEmpty;
	logic [63:0] usecCount;

	periphRegs regs
	(
		.clock(clock), .rst(rst),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.txPush(txPush), .txByte(txByte), .txFull(txFull), .txEmpty(txEmpty),
		.rxPop(rxPop), .rxHead(rxHead), .rxFull(rxFull), .rxEmpty(rxEmpty),
		.usecCount(usecCount),
		.gpioIn(gpioIn), .gpioOut(gpioOut), .gpioDir(gpioDir)
	);

	byteFifo txFifo
	(
		.clock(clock), .rst(rst),
		.push(txPush), .pushByte(txByte),
		.pop(txPop), .popHead(txHead),
		.full(txFull), .empty(txEmpty)
	);

	byteFifo rxFifo
	(
		.clock(clock), .rst(rst),
		.push(rxPush), .pushByte(rxByte),
		.pop(rxPop), .popHead(rxHead),
		.full(rxFull), .empty(rxEmpty)
	);

	uartTx tx
	(
		.clock(clock), .rst(rst),
		.head(txHead), .empty(txEmpty), .pop(txPop),
		.txd(txd)
	);

	uartRx rx
	(
		.clock(clock), .rst(rst),
		.rxd(rxd), .push(rxPush), .byteOut(rxByte)
	);

	usecTimer timer
	(
		.clock(clock), .rst(rst),
		.count(usecCount)
	);

endmodule

`default_nettype wire

/* hw/periphRegs.sv */
// AXI4-Lite register front end for the timer, UART FIFOs and GPIO
// one outstanding write and one outstanding read, whole-word writes only
`timescale 1ns/100ps
`default_nettype none

module periphRegs
(
	input  logic        clock,
	input  logic        rst,

	input  logic        awvalid,
	output logic        awready,
	input  logic [11:0] awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp,
	input  logic        arvalid,
	output logic        arready,
	input  logic [11:0] araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,

	output logic        txPush,
	output logic [7:0]  txByte,
	input  logic        txFull,
	input  logic        txEmpty,
	output logic        rxPop,
	input  logic [7:0]  rxHead,
	input  logic        rxFull,
	input  logic        rxEmpty,

	input  logic [63:0] usecCount,

	input  logic [31:0] gpioIn,
	output logic [31:0] gpioOut,
	output logic [31:0] gpioDir
);

	logic wrHs;
	logic arHs;
	logic [31:0] readData;
	logic [31:0] hiLatch;

	function automatic logic mapped(input logic [11:0] addr);
		case (addr)
			periphPkg::timerLo, periphPkg::timerHi,
			periphPkg::uartRxData, periphPkg::uartTxData, periphPkg::uartStatus,
			periphPkg::gpioIn, periphPkg::gpioOut, periphPkg::gpioDir,
			periphPkg::gpioSet, periphPkg::gpioClr:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// address and data are taken together, one write in flight
	assign wrHs    = awvalid && wvalid && !bvalid;
	assign awready = wrHs;
	assign wready  = wrHs;

	assign arHs    = arvalid && !rvalid;
	assign arready = arHs;

	assign txPush = wrHs && (awaddr == periphPkg::uartTxData);
	assign txByte = wdata[7:0];
	assign rxPop  = arHs && (araddr == periphPkg::uartRxData);

	always_comb
	begin
		readData = '0;
		case (araddr)
			periphPkg::timerLo:    readData = usecCount[31:0];
			periphPkg::timerHi:    readData = hiLatch;
			periphPkg::uartRxData: readData = rxEmpty ? '0 : {24'b0, rxHead};
			periphPkg::uartStatus: readData = {28'b0, txFull, txEmpty, rxFull, !rxEmpty};
			periphPkg::gpioIn:     readData = gpioIn;
			periphPkg::gpioOut:    readData = gpioOut;
			periphPkg::gpioDir:    readData = gpioDir;
			default:               readData = '0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			bvalid  <= 1'b0;
			bresp   <= periphPkg::okay;
			gpioOut <= '0;
			gpioDir <= '0;
		end
		else if (wrHs)
		begin
			bvalid <= 1'b1;
			bresp  <= mapped(awaddr) ? periphPkg::okay : periphPkg::slvErr;
			case (awaddr)
				periphPkg::gpioOut: gpioOut <= wdata;
				periphPkg::gpioDir: gpioDir <= wdata;
				periphPkg::gpioSet: gpioOut <= gpioOut | wdata;
				periphPkg::gpioClr: gpioOut <= gpioOut & ~wdata;
				default:            gpioOut <= gpioOut;
			endcase
		end
		else if (bready)
		begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			rvalid  <= 1'b0;
			hiLatch <= '0;
		end
		else if (arHs)
		begin
			rvalid <= 1'b1;
			// upper half frozen so timerHi matches the low word just read
			if (araddr == periphPkg::timerLo)
				hiLatch <= usecCount[63:32];
		end
		else if (rready)
		begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (arHs)
		begin
			rdata <= readData;
			rresp <= mapped(araddr) ? periphPkg::okay : periphPkg::slvErr;
		end
	end

	assertBHold: assert property (@(posedge clock) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid dropped or bresp changed before bready");

	assertRHold: assert property (@(posedge clock) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("rvalid dropped or read data changed before rready");

endmodule

`default_nettype wire

/* hw/usecTimer.sv */
// free-running microsecond counter
// a 16-bit phase accumulator yields one tick per microsecond on average
`timescale 1ns/100ps
`default_nettype none

module usecTimer
(
	input  logic        clock,
	input  logic        rst,
	output logic [63:0] count
);

	logic [15:0] acc;
	logic [16:0] sum;
	logic tick;

	assign sum = {1'b0, acc} + {1'b0, periphPkg::tickStep};

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			acc   <= '0;
			tick  <= 1'b0;
			count <= '0;
		end
		else
		begin
			acc  <= sum[15:0];
			// carry out of the accumulator is one microsecond
			tick <= sum[16];
			if (tick)
				count <= count + 64'd1;
		end
	end

endmodule

`default_nettype wire

/* hw/uartRx.sv */
// 8N1 UART receiver feeding the RX byte FIFO
// bytes with a low stop bit are discarded
`timescale 1ns/100ps
`default_nettype none

module uartRx
(
	input  logic       clock,
	input  logic       rst,
	input  logic       rxd,
	output logic       push,
	output logic [7:0] byteOut
);

	localparam int cntBits = $clog2(periphPkg::bitClocks);

	periphPkg::rxState state;
	logic [cntBits-1:0] bitCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic rxMeta;
	logic rxSync;
	logic rxPrev;
	logic lastClock;
	logic halfClock;

	assign lastClock = bitCnt == cntBits'(periphPkg::bitClocks - 1);
	assign halfClock = bitCnt == cntBits'(periphPkg::bitClocks / 2 - 1);
	assign byteOut   = shiftReg;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state  <= periphPkg::rxIdle;
			bitCnt <= '0;
			bitIdx <= '0;
			push   <= 1'b0;
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
			push   <= 1'b0;
			bitCnt <= bitCnt + 1'b1;
			case (state)
				periphPkg::rxIdle:
				begin
					bitCnt <= '0;
					if (rxPrev && !rxSync)
						state <= periphPkg::rxStart;
				end
				periphPkg::rxStart:
				begin
					// a start bit gone high by mid-bit was a glitch
					if (halfClock)
					begin
						bitCnt <= '0;
						bitIdx <= '0;
						state  <= rxSync ? periphPkg::rxIdle : periphPkg::rxData;
					end
				end
				periphPkg::rxData:
				begin
					if (lastClock)
					begin
						bitCnt <= '0;
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= periphPkg::rxStop;
					end
				end
				default:
				begin
					if (lastClock)
					begin
						bitCnt <= '0;
						push   <= rxSync;
						state  <= periphPkg::rxIdle;
					end
				end
			endcase
		end
	end

	// sampled at each bit center
	always_ff @(posedge clock)
	begin
		if (state == periphPkg::rxData && lastClock)
			shiftReg <= {rxSync, shiftReg[7:1]};
	end

	assertStartWindow: assert property (@(posedge clock) disable iff (rst)
		state == periphPkg::rxStart |-> bitCnt < cntBits'(periphPkg::bitClocks / 2))
		else $error("bitCnt past mid-bit while rxState is rxStart");

endmodule

`default_nettype wire

/* hw/uartTx.sv */
// 8N1 UART transmitter fed from the TX byte FIFO
// frames go out back to back while the FIFO holds data
`timescale 1ns/100ps
`default_nettype none

module uartTx
(
	input  logic       clock,
	input  logic       rst,
	input  logic [7:0] head,
	input  logic       empty,
	output logic       pop,
	output logic       txd
);

	localparam int cntBits = $clog2(periphPkg::bitClocks);

	periphPkg::txState state;
	logic [cntBits-1:0] bitCnt;
	logic [2:0] bitIdx;
	logic [7:0] shiftReg;
	logic lastClock;
	logic lineNext;

	assign lastClock = bitCnt == cntBits'(periphPkg::bitClocks - 1);

	// take the next byte from idle or straight at the end of a stop bit
	assign pop = !empty && ((state == periphPkg::txIdle) ||
		(state == periphPkg::txStop && lastClock));

	always_comb
	begin
		case (state)
			periphPkg::txStart: lineNext = 1'b0;
			periphPkg::txData:  lineNext = shiftReg[0];
			default:            lineNext = 1'b1;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state  <= periphPkg::txIdle;
			bitCnt <= '0;
			bitIdx <= '0;
			txd    <= 1'b1;
		end
		else
		begin
			txd    <= lineNext;
			bitCnt <= (state == periphPkg::txIdle || lastClock) ? '0 : bitCnt + 1'b1;
			case (state)
				periphPkg::txIdle:
				begin
					if (pop)
						state <= periphPkg::txStart;
				end
				periphPkg::txStart:
				begin
					if (lastClock)
					begin
						state  <= periphPkg::txData;
						bitIdx <= '0;
					end
				end
				periphPkg::txData:
				begin
					if (lastClock)
					begin
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7)
							state <= periphPkg::txStop;
					end
				end
				default:
				begin
					if (lastClock)
						state <= pop ? periphPkg::txStart : periphPkg::txIdle;
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clock)
	begin
		if (pop)
			shiftReg <= head;
		else if (state == periphPkg::txData && lastClock)
			shiftReg <= {1'b1, shiftReg[7:1]};
	end

	assertIdleHigh: assert property (@(posedge clock) disable iff (rst)
		state == periphPkg::txIdle |-> txd)
		else $error("txd low while txState is txIdle");

endmodule

`default_nettype wire

/* hw/byteFifo.sv */
// byte FIFO between the register front end and a UART engine
// pushes to a full FIFO and pops from an empty one are ignored
`timescale 1ns/100ps
`default_nettype none

module byteFifo
(
	input  logic       clock,
	input  logic       rst,
	input  logic       push,
	input  logic [7:0] pushByte,
	input  logic       pop,
	output logic [7:0] popHead,
	output logic       full,
	output logic       empty
);

	localparam int ptrBits = $clog2(periphPkg::fifoDepth);
	localparam int cntBits = $clog2(periphPkg::fifoDepth + 1);

	logic [7:0] mem [periphPkg::fifoDepth];
	logic [ptrBits-1:0] wrPtr;
	logic [ptrBits-1:0] rdPtr;
	logic [cntBits-1:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
		return (ptr == ptrBits'(periphPkg::fifoDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPush  = push && !full;
	assign doPop   = pop && !empty;
	assign full    = count == cntBits'(periphPkg::fifoDepth);
	assign empty   = count == '0;
	assign popHead = mem[rdPtr];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (doPush)
			mem[wrPtr] <= pushByte;
	end

	assertCount: assert property (@(posedge clock) disable iff (rst)
		count <= cntBits'(periphPkg::fifoDepth))
		else $error("FIFO occupancy above depth");

endmodule

`default_nettype wire

/* hw/periphPkg.sv */
// shared constants and types for the peripheral block
// register map, AXI response codes, UART engine states and fixed rates
`default_nettype none

package periphPkg;

	// register offsets within the 4 KB window
	typedef enum logic [11:0]
	{
		timerLo    = 12'h000,
		timerHi    = 12'h004,
		uartRxData = 12'h010,
		uartTxData = 12'h014,
		uartStatus = 12'h018,
		gpioIn     = 12'h020,
		gpioOut    = 12'h024,
		gpioDir    = 12'h028,
		gpioSet    = 12'h030,
		gpioClr    = 12'h034
	} regOffset;

	typedef enum logic [1:0]
	{
		okay   = 2'd0,
		slvErr = 2'd2
	} axiResp;

	typedef enum logic [1:0]
	{
		txIdle,
		txStart,
		txData,
		txStop
	} txState;

	typedef enum logic [1:0]
	{
		rxIdle,
		rxStart,
		rxData,
		rxStop
	} rxState;

	localparam int fifoDepth = 8;
	localparam int bitClocks = 16;

	// 65536 / 524 clocks per microsecond at 125 MHz
	localparam logic [15:0] tickStep = 16'd524;

endpackage

`default_nettype wire
